/* compile.f */
source/rob_cfg_pkg.sv
source/rob_state_pkg.sv
source/rob_alloc.sv
source/rob_entry.sv
source/rob_retire.sv
source/rob_top.sv
verif/rob_tb.sv

/* source/rob_alloc.sv */
// Tail side of the buffer. Assumes DP_NUM and RT_NUM do not exceed ROB_ENTRIES.
// dp_num_i above avail_o is not checked and corrupts the occupancy count.
`default_nettype none

module rob_alloc #(
    parameter  int ROB_ENTRIES = rob_cfg_pkg::DEF_ROB_ENTRIES,
    parameter  int DP_NUM      = rob_cfg_pkg::DEF_DP_NUM,
    parameter  int RT_NUM      = rob_cfg_pkg::DEF_RT_NUM,
    localparam int IDX_W       = $clog2(ROB_ENTRIES),
    localparam int CNT_W       = $clog2(ROB_ENTRIES + 1),
    localparam int DP_CNT_W    = $clog2(DP_NUM + 1),
    localparam int RT_CNT_W    = $clog2(RT_NUM + 1),
    localparam int SLOT_W      = (DP_NUM > 1) ? $clog2(DP_NUM) : 1
) (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  logic [DP_CNT_W-1:0]                 dp_num_i,
    input  logic [RT_CNT_W-1:0]                 rt_count_i,
    input  rob_state_pkg::flush_cause_e         flush_cause_i,
    output logic [DP_CNT_W-1:0]                 avail_o,
    output logic [DP_NUM-1:0][IDX_W-1:0]        dp_rob_idx_o,
    output logic [ROB_ENTRIES-1:0]              entry_wr_en_o,
    output logic [ROB_ENTRIES-1:0][SLOT_W-1:0]  entry_wr_slot_o
);

    logic [IDX_W-1:0]                   tail_q;
    logic [CNT_W-1:0]                   occ_q;
    logic [CNT_W:0]                     free_cnt;
    logic [ROB_ENTRIES-1:0][IDX_W-1:0]  entry_off;

    // Sum below twice the entry count folded back into range
    function automatic logic [IDX_W-1:0] wrap_idx(input logic [IDX_W:0] sum);
        if (sum >= ROB_ENTRIES) begin
            return IDX_W'(sum - ROB_ENTRIES);
        end
        return IDX_W'(sum);
    endfunction

    // --------------------------------------------------
    // Tail pointer and occupancy
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i || flush_cause_i != rob_state_pkg::FLUSH_NONE) begin
            tail_q <= '0;
            occ_q  <= '0;
        end else begin
            tail_q <= wrap_idx((IDX_W+1)'(tail_q) + (IDX_W+1)'(dp_num_i));
            // Entries in flight after this edge
            occ_q  <= occ_q + CNT_W'(dp_num_i) - CNT_W'(rt_count_i);
        end
    end

    // --------------------------------------------------
    // Free count toward dispatch
    // --------------------------------------------------
    always_comb begin
        // Retiring entries count as free in the same cycle
        free_cnt = (CNT_W+1)'(ROB_ENTRIES) - (CNT_W+1)'(occ_q) + (CNT_W+1)'(rt_count_i);
        if (free_cnt > DP_NUM) begin
            avail_o = DP_CNT_W'(DP_NUM);
        end else begin
            avail_o = DP_CNT_W'(free_cnt);
        end
    end

    // Index handed back per dispatch slot
    always_comb begin
        for (int s = 0; s < DP_NUM; s++) begin
            dp_rob_idx_o[s] = wrap_idx((IDX_W+1)'(tail_q) + (IDX_W+1)'(s));
        end
    end

    // --------------------------------------------------
    // Per-entry write selection
    // --------------------------------------------------
    always_comb begin
        for (int k = 0; k < ROB_ENTRIES; k++) begin
            // Distance of entry k past the tail, modulo the entry count
            entry_off[k]       = wrap_idx((IDX_W+1)'(k + ROB_ENTRIES) - (IDX_W+1)'(tail_q));
            // Wrapping run of dp_num_i entries starting at the tail
            entry_wr_en_o[k]   = (IDX_W+1)'(entry_off[k]) < (IDX_W+1)'(dp_num_i);
            entry_wr_slot_o[k] = entry_off[k][SLOT_W-1:0];
        end
    end

endmodule

`default_nettype wire

/* source/rob_cfg_pkg.sv */
// Machine sizes fixed for the core and default widths of the reorder buffer.
// Register counts are not parameters. Change them here only.
`default_nettype none

package rob_cfg_pkg;

    // --------------------------------------------------
    // Register file sizes
    // --------------------------------------------------

    // Architectural register file
    localparam int ARCH_REG_NUM = 32;
    localparam int ARCH_IDX_W   = $clog2(ARCH_REG_NUM);

    // Physical register file, one tag per register
    localparam int PHY_REG_NUM  = 64;
    localparam int TAG_W        = $clog2(PHY_REG_NUM);

    // --------------------------------------------------
    // Buffer defaults, overridable at rob_top
    // --------------------------------------------------

    // Entry count, need not be a power of two
    localparam int DEF_ROB_ENTRIES = 8;

    // Dispatch slots per cycle
    localparam int DEF_DP_NUM      = 2;

    // Broadcast channels
    localparam int DEF_CDB_NUM     = 2;

    // Retire slots per cycle
    localparam int DEF_RT_NUM      = 2;

endpackage

`default_nettype wire

/* source/rob_entry.sv */
// One reorder buffer entry. A broadcast in its dispatch cycle is lost.
// The payload has no reset and holds stale data while the entry is empty.
`default_nettype none

module rob_entry #(
    parameter  int ENTRY_IDX   = 0,
    parameter  int ROB_ENTRIES = rob_cfg_pkg::DEF_ROB_ENTRIES,
    parameter  int DP_NUM      = rob_cfg_pkg::DEF_DP_NUM,
    parameter  int CDB_NUM     = rob_cfg_pkg::DEF_CDB_NUM,
    localparam int IDX_W       = $clog2(ROB_ENTRIES),
    localparam int SLOT_W      = (DP_NUM > 1) ? $clog2(DP_NUM) : 1
) (
    input  logic                                            clk_i,
    input  logic                                            rst_i,
    input  rob_state_pkg::flush_cause_e                     flush_cause_i,
    input  logic                                            wr_en_i,
    input  logic [SLOT_W-1:0]                               wr_slot_i,
    input  logic [DP_NUM-1:0][rob_cfg_pkg::ARCH_IDX_W-1:0]  dp_rd_i,
    input  logic [DP_NUM-1:0][rob_cfg_pkg::TAG_W-1:0]       dp_tag_i,
    input  logic [DP_NUM-1:0][rob_cfg_pkg::TAG_W-1:0]       dp_tag_old_i,
    input  logic [DP_NUM-1:0]                               dp_br_predict_i,
    input  logic [CDB_NUM-1:0]                              cdb_valid_i,
    input  logic [CDB_NUM-1:0][IDX_W-1:0]                   cdb_rob_idx_i,
    input  logic [CDB_NUM-1:0]                              cdb_br_result_i,
    input  logic                                            retire_i,
    output rob_state_pkg::entry_state_e                     state_o,
    output logic [rob_cfg_pkg::ARCH_IDX_W-1:0]              rd_o,
    output logic [rob_cfg_pkg::TAG_W-1:0]                   tag_o,
    output logic [rob_cfg_pkg::TAG_W-1:0]                   tag_old_o,
    output logic                                            mispredict_o
);

    rob_state_pkg::entry_state_e state_q;
    logic                        br_predict_q;
    logic                        br_result_q;
    logic                        cdb_hit;
    logic                        cdb_result;
    logic                        complete;

    // --------------------------------------------------
    // CDB match against this entry's index
    // --------------------------------------------------
    always_comb begin
        cdb_hit    = 1'b0;
        cdb_result = 1'b0;
        for (int c = 0; c < CDB_NUM; c++) begin
            if (cdb_valid_i[c] && cdb_rob_idx_i[c] == IDX_W'(ENTRY_IDX)) begin
                cdb_hit    = 1'b1;
                cdb_result = cdb_br_result_i[c];
            end
        end
    end

    // Only a waiting entry accepts an outcome
    assign complete = cdb_hit && state_q == rob_state_pkg::ENTRY_WAITING;

    // Lifecycle, flush wins over everything but reset
    always_ff @(posedge clk_i) begin
        if (rst_i || flush_cause_i != rob_state_pkg::FLUSH_NONE) begin
            state_q <= rob_state_pkg::ENTRY_EMPTY;
        end else if (wr_en_i) begin
            state_q <= rob_state_pkg::ENTRY_WAITING;
        end else if (retire_i) begin
            state_q <= rob_state_pkg::ENTRY_EMPTY;
        end else if (complete) begin
            state_q <= rob_state_pkg::ENTRY_DONE;
        end
    end

    // Payload picked from the dispatch slot assigned by the allocator
    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            rd_o         <= dp_rd_i[wr_slot_i];
            tag_o        <= dp_tag_i[wr_slot_i];
            tag_old_o    <= dp_tag_old_i[wr_slot_i];
            br_predict_q <= dp_br_predict_i[wr_slot_i];
        end
        if (complete) begin
            br_result_q  <= cdb_result;
        end
    end

    assign state_o      = state_q;
    // Meaningful only once done; non-branches complete with result equal to prediction
    assign mispredict_o = br_predict_q ^ br_result_q;

endmodule

`default_nettype wire

/* source/rob_retire.sv */
// Head side of the buffer. Retire and flush decisions are combinational from
// the head entries. Assumes RT_NUM does not exceed ROB_ENTRIES.
`default_nettype none

module rob_retire #(
    parameter  int ROB_ENTRIES = rob_cfg_pkg::DEF_ROB_ENTRIES,
    parameter  int RT_NUM      = rob_cfg_pkg::DEF_RT_NUM,
    localparam int IDX_W       = $clog2(ROB_ENTRIES),
    localparam int RT_CNT_W    = $clog2(RT_NUM + 1)
) (
    input  logic                                                clk_i,
    input  logic                                                rst_i,
    input  logic                                                exception_i,
    input  rob_state_pkg::entry_state_e [ROB_ENTRIES-1:0]       entry_state_i,
    input  logic [ROB_ENTRIES-1:0][rob_cfg_pkg::ARCH_IDX_W-1:0] entry_rd_i,
    input  logic [ROB_ENTRIES-1:0][rob_cfg_pkg::TAG_W-1:0]      entry_tag_i,
    input  logic [ROB_ENTRIES-1:0][rob_cfg_pkg::TAG_W-1:0]      entry_tag_old_i,
    input  logic [ROB_ENTRIES-1:0]                              entry_mispredict_i,
    output logic [ROB_ENTRIES-1:0]                              entry_retire_o,
    output logic [RT_CNT_W-1:0]                                 rt_count_o,
    output rob_state_pkg::flush_cause_e                         flush_cause_o,
    output logic [RT_NUM-1:0]                                   rt_valid_o,
    output logic [RT_NUM-1:0][rob_cfg_pkg::ARCH_IDX_W-1:0]      rt_arch_reg_o,
    output logic [RT_NUM-1:0][rob_cfg_pkg::TAG_W-1:0]           rt_tag_o,
    output logic [RT_NUM-1:0][rob_cfg_pkg::TAG_W-1:0]           rt_tag_old_o,
    output logic                                                br_mis_o
);

    logic [IDX_W-1:0]              head_q;
    logic [RT_NUM-1:0][IDX_W-1:0]  slot_idx;
    logic                          chain_ok;
    logic                          mis_found;

    // Sum below twice the entry count folded back into range
    function automatic logic [IDX_W-1:0] wrap_idx(input logic [IDX_W:0] sum);
        if (sum >= ROB_ENTRIES) begin
            return IDX_W'(sum - ROB_ENTRIES);
        end
        return IDX_W'(sum);
    endfunction

    // --------------------------------------------------
    // In-order retire chain from the head
    // --------------------------------------------------
    always_comb begin
        // Exception blocks every slot
        chain_ok       = !exception_i;
        mis_found      = 1'b0;
        entry_retire_o = '0;
        rt_count_o     = '0;
        for (int s = 0; s < RT_NUM; s++) begin
            slot_idx[s]   = wrap_idx((IDX_W+1)'(head_q) + (IDX_W+1)'(s));
            rt_valid_o[s] = chain_ok && entry_state_i[slot_idx[s]] == rob_state_pkg::ENTRY_DONE;
            if (rt_valid_o[s]) begin
                entry_retire_o[slot_idx[s]] = 1'b1;
                rt_count_o                  = rt_count_o + RT_CNT_W'(1);
                if (entry_mispredict_i[slot_idx[s]]) begin
                    mis_found = 1'b1;
                end
            end
            // Chain breaks after an undone entry or a mispredicted branch
            chain_ok = rt_valid_o[s] && !entry_mispredict_i[slot_idx[s]];
        end
    end

    // --------------------------------------------------
    // Payload to map table and free list
    // --------------------------------------------------
    always_comb begin
        for (int s = 0; s < RT_NUM; s++) begin
            rt_arch_reg_o[s] = entry_rd_i[slot_idx[s]];
            rt_tag_o[s]      = entry_tag_i[slot_idx[s]];
            rt_tag_old_o[s]  = entry_tag_old_i[slot_idx[s]];
        end
    end

    // --------------------------------------------------
    // Flush cause
    // --------------------------------------------------
    assign br_mis_o = mis_found;

    always_comb begin
        // Exception first, mispredict cannot be seen under it anyway
        if (exception_i) begin
            flush_cause_o = rob_state_pkg::FLUSH_EXCEPTION;
        end else if (mis_found) begin
            flush_cause_o = rob_state_pkg::FLUSH_MISPREDICT;
        end else begin
            flush_cause_o = rob_state_pkg::FLUSH_NONE;
        end
    end

    // Head pointer, back to zero on any flush
    always_ff @(posedge clk_i) begin
        if (rst_i || flush_cause_o != rob_state_pkg::FLUSH_NONE) begin
            head_q <= '0;
        end else begin
            head_q <= wrap_idx((IDX_W+1)'(head_q) + (IDX_W+1)'(rt_count_o));
        end
    end

endmodule

`default_nettype wire

/* source/rob_state_pkg.sv */
// Entry lifecycle and flush cause encodings, both two bits wide.
`default_nettype none

package rob_state_pkg;

    // Entry lifecycle
    // Empty -> waiting on dispatch, waiting -> done on CDB hit
    typedef enum logic [1:0] {
        ENTRY_EMPTY   = 2'd0,
        ENTRY_WAITING = 2'd1,
        ENTRY_DONE    = 2'd2
    } entry_state_e;

    // Why the buffer is flushed this cycle
    typedef enum logic [1:0] {
        FLUSH_NONE       = 2'd0,
        FLUSH_EXCEPTION  = 2'd1,
        FLUSH_MISPREDICT = 2'd2
    } flush_cause_e;

endpackage

`default_nettype wire

/* source/rob_top.sv */
// Reorder buffer top. dp_num_i must not exceed avail_o in the same cycle.
// Retire and completion have no back-pressure.
`default_nettype none

module rob_top #(
    parameter  int ROB_ENTRIES = rob_cfg_pkg::DEF_ROB_ENTRIES,
    parameter  int DP_NUM      = rob_cfg_pkg::DEF_DP_NUM,
    parameter  int CDB_NUM     = rob_cfg_pkg::DEF_CDB_NUM,
    parameter  int RT_NUM      = rob_cfg_pkg::DEF_RT_NUM,
    localparam int IDX_W       = $clog2(ROB_ENTRIES),
    localparam int DP_CNT_W    = $clog2(DP_NUM + 1)
) (
    input  logic                                            clk_i,
    input  logic                                            rst_i,
    // Dispatch
    input  logic [DP_CNT_W-1:0]                             dp_num_i,
    input  logic [DP_NUM-1:0][rob_cfg_pkg::ARCH_IDX_W-1:0]  dp_rd_i,
    input  logic [DP_NUM-1:0][rob_cfg_pkg::TAG_W-1:0]       dp_tag_i,
    input  logic [DP_NUM-1:0][rob_cfg_pkg::TAG_W-1:0]       dp_tag_old_i,
    input  logic [DP_NUM-1:0]                               dp_br_predict_i,
    output logic [DP_CNT_W-1:0]                             avail_o,
    output logic [DP_NUM-1:0][IDX_W-1:0]                    dp_rob_idx_o,
    // Completion broadcast
    input  logic [CDB_NUM-1:0]                              cdb_valid_i,
    input  logic [CDB_NUM-1:0][IDX_W-1:0]                   cdb_rob_idx_i,
    input  logic [CDB_NUM-1:0]                              cdb_br_result_i,
    // Retire and flush
    input  logic                                            exception_i,
    output logic [RT_NUM-1:0]                               rt_valid_o,
    output logic [RT_NUM-1:0][rob_cfg_pkg::ARCH_IDX_W-1:0]  rt_arch_reg_o,
    output logic [RT_NUM-1:0][rob_cfg_pkg::TAG_W-1:0]       rt_tag_o,
    output logic [RT_NUM-1:0][rob_cfg_pkg::TAG_W-1:0]       rt_tag_old_o,
    output logic                                            br_mis_o
);

    localparam int RT_CNT_W = $clog2(RT_NUM + 1);
    localparam int SLOT_W   = (DP_NUM > 1) ? $clog2(DP_NUM) : 1;

    logic [ROB_ENTRIES-1:0]                              entry_wr_en;
    logic [ROB_ENTRIES-1:0][SLOT_W-1:0]                  entry_wr_slot;
    logic [ROB_ENTRIES-1:0]                              entry_retire;
    rob_state_pkg::entry_state_e [ROB_ENTRIES-1:0]       entry_state;
    logic [ROB_ENTRIES-1:0][rob_cfg_pkg::ARCH_IDX_W-1:0] entry_rd;
    logic [ROB_ENTRIES-1:0][rob_cfg_pkg::TAG_W-1:0]      entry_tag;
    logic [ROB_ENTRIES-1:0][rob_cfg_pkg::TAG_W-1:0]      entry_tag_old;
    logic [ROB_ENTRIES-1:0]                              entry_mispredict;
    logic [RT_CNT_W-1:0]                                 rt_count;
    rob_state_pkg::flush_cause_e                         flush_cause;

    rob_alloc #(
        .ROB_ENTRIES(ROB_ENTRIES),
        .DP_NUM     (DP_NUM),
        .RT_NUM     (RT_NUM)
    ) u_alloc (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .dp_num_i       (dp_num_i),
        .rt_count_i     (rt_count),
        .flush_cause_i  (flush_cause),
        .avail_o        (avail_o),
        .dp_rob_idx_o   (dp_rob_idx_o),
        .entry_wr_en_o  (entry_wr_en),
        .entry_wr_slot_o(entry_wr_slot)
    );

    // One entry per index, each matching the CDB on its own
    for (genvar k = 0; k < ROB_ENTRIES; k++) begin : g_entry
        rob_entry #(
            .ENTRY_IDX  (k),
            .ROB_ENTRIES(ROB_ENTRIES),
            .DP_NUM     (DP_NUM),
            .CDB_NUM    (CDB_NUM)
        ) u_entry (
            .clk_i          (clk_i),
            .rst_i          (rst_i),
            .flush_cause_i  (flush_cause),
            .wr_en_i        (entry_wr_en[k]),
            .wr_slot_i      (entry_wr_slot[k]),
            .dp_rd_i        (dp_rd_i),
            .dp_tag_i       (dp_tag_i),
            .dp_tag_old_i   (dp_tag_old_i),
            .dp_br_predict_i(dp_br_predict_i),
            .cdb_valid_i    (cdb_valid_i),
            .cdb_rob_idx_i  (cdb_rob_idx_i),
            .cdb_br_result_i(cdb_br_result_i),
            .retire_i       (entry_retire[k]),
            .state_o        (entry_state[k]),
            .rd_o           (entry_rd[k]),
            .tag_o          (entry_tag[k]),
            .tag_old_o      (entry_tag_old[k]),
            .mispredict_o   (entry_mispredict[k])
        );
    end

    rob_retire #(
        .ROB_ENTRIES(ROB_ENTRIES),
        .RT_NUM     (RT_NUM)
    ) u_retire (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .exception_i       (exception_i),
        .entry_state_i     (entry_state),
        .entry_rd_i        (entry_rd),
        .entry_tag_i       (entry_tag),
        .entry_tag_old_i   (entry_tag_old),
        .entry_mispredict_i(entry_mispredict),
        .entry_retire_o    (entry_retire),
        .rt_count_o        (rt_count),
        .flush_cause_o     (flush_cause),
        .rt_valid_o        (rt_valid_o),
        .rt_arch_reg_o     (rt_arch_reg_o),
        .rt_tag_o          (rt_tag_o),
        .rt_tag_old_o      (rt_tag_old_o),
        .br_mis_o          (br_mis_o)
    );

endmodule

`default_nettype wire

/* verif/rob_tb.sv */
// Testbench for rob_top at default sizes. An in-order queue model predicts every output.
// Stimulus never dispatches above the model's free count.
`default_nettype none

module rob_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int ENTRIES    = rob_cfg_pkg::DEF_ROB_ENTRIES;
    localparam int DP_NUM     = rob_cfg_pkg::DEF_DP_NUM;
    localparam int CDB_NUM    = rob_cfg_pkg::DEF_CDB_NUM;
    localparam int RT_NUM     = rob_cfg_pkg::DEF_RT_NUM;
    localparam int AW         = rob_cfg_pkg::ARCH_IDX_W;
    localparam int TW         = rob_cfg_pkg::TAG_W;
    localparam int IDX_W      = $clog2(ENTRIES);
    localparam int DP_CNT_W   = $clog2(DP_NUM + 1);
    localparam int MAX_CYCLES = 2000;

    // One dispatched instruction as the model sees it
    typedef struct packed {
        logic [IDX_W-1:0] idx;
        logic [AW-1:0]    rd;
        logic [TW-1:0]    tag;
        logic [TW-1:0]    tag_old;
        logic             pred;
        logic             done;
        logic             res;
    } rob_rec_t;

    logic                           clk_i;
    logic                           rst_i;
    logic [DP_CNT_W-1:0]            dp_num_i;
    logic [DP_NUM-1:0][AW-1:0]      dp_rd_i;
    logic [DP_NUM-1:0][TW-1:0]      dp_tag_i;
    logic [DP_NUM-1:0][TW-1:0]      dp_tag_old_i;
    logic [DP_NUM-1:0]              dp_br_predict_i;
    logic [DP_CNT_W-1:0]            avail_o;
    logic [DP_NUM-1:0][IDX_W-1:0]   dp_rob_idx_o;
    logic [CDB_NUM-1:0]             cdb_valid_i;
    logic [CDB_NUM-1:0][IDX_W-1:0]  cdb_rob_idx_i;
    logic [CDB_NUM-1:0]             cdb_br_result_i;
    logic                           exception_i;
    logic [RT_NUM-1:0]              rt_valid_o;
    logic [RT_NUM-1:0][AW-1:0]      rt_arch_reg_o;
    logic [RT_NUM-1:0][TW-1:0]      rt_tag_o;
    logic [RT_NUM-1:0][TW-1:0]      rt_tag_old_o;
    logic                           br_mis_o;

    rob_rec_t model_q[$];
    int       model_tail;
    int       cycle_cnt;
    int       exp_n;
    int       free_cnt;
    logic [RT_NUM-1:0] exp_valid;
    logic              exp_mis;

    rob_top #(
        .ROB_ENTRIES(ENTRIES),
        .DP_NUM     (DP_NUM),
        .CDB_NUM    (CDB_NUM),
        .RT_NUM     (RT_NUM)
    ) u_dut (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .dp_num_i       (dp_num_i),
        .dp_rd_i        (dp_rd_i),
        .dp_tag_i       (dp_tag_i),
        .dp_tag_old_i   (dp_tag_old_i),
        .dp_br_predict_i(dp_br_predict_i),
        .avail_o        (avail_o),
        .dp_rob_idx_o   (dp_rob_idx_o),
        .cdb_valid_i    (cdb_valid_i),
        .cdb_rob_idx_i  (cdb_rob_idx_i),
        .cdb_br_result_i(cdb_br_result_i),
        .exception_i    (exception_i),
        .rt_valid_o     (rt_valid_o),
        .rt_arch_reg_o  (rt_arch_reg_o),
        .rt_tag_o       (rt_tag_o),
        .rt_tag_old_o   (rt_tag_old_o),
        .br_mis_o       (br_mis_o)
    );

    always #5 clk_i = ~clk_i;

    task automatic report_mismatch(input string what, input int got, input int exp);
        $display("[FAIL] %0t: %s is %0d, expected %0d", $time, what, got, exp);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    // Done entries from the model head up to the first mispredict
    function automatic int predict_group(output logic [RT_NUM-1:0] v, output logic mis);
        int  n;
        logic ok;
        n   = 0;
        v   = '0;
        mis = 1'b0;
        ok  = !exception_i;
        for (int s = 0; s < RT_NUM; s++) begin
            if (ok && s < model_q.size() && model_q[s].done) begin
                v[s] = 1'b1;
                n++;
                if (model_q[s].pred != model_q[s].res) begin
                    mis = 1'b1;
                    ok  = 1'b0;
                end
            end else begin
                ok = 1'b0;
            end
        end
        return n;
    endfunction

    // Free entries including this cycle's retires and capped at the dispatch width
    function automatic int model_avail();
        logic [RT_NUM-1:0] v;
        logic              m;
        int                f;
        f = ENTRIES - model_q.size() + predict_group(v, m);
        return (f > DP_NUM) ? DP_NUM : f;
    endfunction

    // --------------------------------------------------
    // Checks at the falling edge followed by the model update
    // --------------------------------------------------
    always @(negedge clk_i) begin
        if (rst_i) begin
            model_q.delete();
            model_tail = 0;
        end else begin
            exp_n    = predict_group(exp_valid, exp_mis);
            free_cnt = model_avail();
            assert (avail_o == DP_CNT_W'(free_cnt))
                else report_mismatch("avail_o", int'(avail_o), free_cnt);
            for (int s = 0; s < DP_NUM; s++) begin
                assert (dp_rob_idx_o[s] == IDX_W'((model_tail + s) % ENTRIES))
                    else report_mismatch("dp_rob_idx_o", int'(dp_rob_idx_o[s]),
                                         (model_tail + s) % ENTRIES);
            end
            assert (rt_valid_o == exp_valid)
                else report_mismatch("rt_valid_o", int'(rt_valid_o), int'(exp_valid));
            assert (br_mis_o == exp_mis)
                else report_mismatch("br_mis_o", int'(br_mis_o), int'(exp_mis));
            for (int s = 0; s < RT_NUM; s++) begin
                if (exp_valid[s]) begin
                    assert (rt_arch_reg_o[s] == model_q[s].rd)
                        else report_mismatch("rt_arch_reg_o", int'(rt_arch_reg_o[s]),
                                             int'(model_q[s].rd));
                    assert (rt_tag_o[s] == model_q[s].tag)
                        else report_mismatch("rt_tag_o", int'(rt_tag_o[s]),
                                             int'(model_q[s].tag));
                    assert (rt_tag_old_o[s] == model_q[s].tag_old)
                        else report_mismatch("rt_tag_old_o", int'(rt_tag_old_o[s]),
                                             int'(model_q[s].tag_old));
                end
            end
            if (exception_i || exp_mis) begin
                // Whole buffer gone and this cycle's dispatches lost too
                model_q.delete();
                model_tail = 0;
            end else begin
                repeat (exp_n) void'(model_q.pop_front());
                // Only entries already waiting take a broadcast
                for (int c = 0; c < CDB_NUM; c++) begin
                    for (int p = 0; p < model_q.size(); p++) begin
                        if (cdb_valid_i[c] && !model_q[p].done
                            && model_q[p].idx == cdb_rob_idx_i[c]) begin
                            model_q[p].done = 1'b1;
                            model_q[p].res  = cdb_br_result_i[c];
                        end
                    end
                end
                for (int s = 0; s < int'(dp_num_i); s++) begin
                    model_q.push_back('{IDX_W'((model_tail + s) % ENTRIES), dp_rd_i[s],
                                        dp_tag_i[s], dp_tag_old_i[s], dp_br_predict_i[s],
                                        1'b0, 1'b0});
                end
                model_tail = (model_tail + int'(dp_num_i)) % ENTRIES;
            end
        end
    end

    // Hang guard
    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout: the test hung and did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    end

    // --------------------------------------------------
    // Stimulus helpers
    // --------------------------------------------------
    task automatic next_cycle();
        @(posedge clk_i);
        #1;
        dp_num_i    = '0;
        cdb_valid_i = '0;
        exception_i = 1'b0;
    endtask

    // Fresh payload per slot with the count capped at the model's free entries
    task automatic dispatch(input int want, input logic [DP_NUM-1:0] pred);
        int n;
        n = model_avail();
        if (want < n) begin
            n = want;
        end
        for (int s = 0; s < DP_NUM; s++) begin
            dp_rd_i[s]      = AW'($urandom);
            dp_tag_i[s]     = TW'($urandom);
            dp_tag_old_i[s] = TW'($urandom);
        end
        dp_br_predict_i = pred;
        dp_num_i        = DP_CNT_W'(n);
    endtask

    // Broadcast on channel ch for model position pos where flip forces a mispredict
    task automatic complete_pos(input int ch, input int pos, input logic flip);
        cdb_valid_i[ch]     = 1'b1;
        cdb_rob_idx_i[ch]   = model_q[pos].idx;
        cdb_br_result_i[ch] = model_q[pos].pred ^ flip;
    endtask

    // Complete the oldest pending entries until the buffer empties
    task automatic drain();
        int ch;
        while (model_q.size() > 0) begin
            next_cycle();
            ch = 0;
            for (int p = 0; p < model_q.size() && ch < CDB_NUM; p++) begin
                if (!model_q[p].done) begin
                    complete_pos(ch, p, 1'b0);
                    ch++;
                end
            end
        end
    endtask

    task automatic random_cycle();
        int pend[$];
        int pick;
        next_cycle();
        exception_i = ($urandom % 100) == 0;
        dispatch($urandom % (DP_NUM + 1), DP_NUM'($urandom));
        for (int p = 0; p < model_q.size(); p++) begin
            if (!model_q[p].done) begin
                pend.push_back(p);
            end
        end
        // Distinct entries per channel and rare mispredicts
        for (int c = 0; c < CDB_NUM; c++) begin
            if (pend.size() > 0 && ($urandom % 4) != 0) begin
                pick = $urandom % pend.size();
                complete_pos(c, pend[pick], ($urandom % 24) == 0);
                pend.delete(pick);
            end
        end
    endtask

    initial begin
        void'($urandom(32'hc514_f21c));
        clk_i           = 1'b0;
        rst_i           = 1'b1;
        dp_num_i        = '0;
        dp_rd_i         = '0;
        dp_tag_i        = '0;
        dp_tag_old_i    = '0;
        dp_br_predict_i = '0;
        cdb_valid_i     = '0;
        cdb_rob_idx_i   = '0;
        cdb_br_result_i = '0;
        exception_i     = 1'b0;
        cycle_cnt       = 0;
        repeat (3) @(posedge clk_i);
        #1 rst_i = 1'b0;
        // Four in flight and completed youngest first
        next_cycle();
        dispatch(2, '0);
        next_cycle();
        dispatch(2, '0);
        for (int p = 3; p >= 0; p--) begin
            next_cycle();
            complete_pos(0, p, 1'b0);
        end
        drain();
        // Gap in the done run stops retire
        next_cycle();
        dispatch(2, '0);
        next_cycle();
        dispatch(2, '0);
        next_cycle();
        complete_pos(0, 0, 1'b0);
        complete_pos(1, 2, 1'b0);
        drain();
        // Fill until no entry is free
        repeat (ENTRIES / DP_NUM + 1) begin
            next_cycle();
            dispatch(DP_NUM, '0);
        end
        drain();
        // Mispredict at the head keeps the done younger entry from committing
        next_cycle();
        dispatch(2, 2'b01);
        next_cycle();
        dispatch(2, '0);
        next_cycle();
        complete_pos(0, 1, 1'b0);
        complete_pos(1, 2, 1'b0);
        next_cycle();
        complete_pos(0, 0, 1'b1);
        next_cycle();
        next_cycle();
        // Mispredict in the second slot commits the older slot with it
        next_cycle();
        dispatch(2, 2'b10);
        next_cycle();
        complete_pos(0, 0, 1'b0);
        complete_pos(1, 1, 1'b1);
        next_cycle();
        next_cycle();
        // Exception over a ready group
        next_cycle();
        dispatch(2, '0);
        next_cycle();
        complete_pos(0, 0, 1'b0);
        complete_pos(1, 1, 1'b0);
        next_cycle();
        exception_i = 1'b1;
        next_cycle();
        next_cycle();
        repeat (900) random_cycle();
        drain();
        next_cycle();
        next_cycle();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire
